// ==== hw/rob_pkg.sv ====
`default_nettype none

package rob_pkg;

    // buffer geometry
    localparam int ROB_DEPTH = 64;
    localparam int IDX_W = 6;

    // index plus one wrap bit, so full and empty differ
    localparam int PTR_W = IDX_W + 1;

    // allocation writes a whole group per strobe
    localparam int GROUP_SIZE = 4;

    // retire at most this many per cycle
    localparam int COMMIT_WIDTH = 4;

    // counts from 0 up to COMMIT_WIDTH
    localparam int CNT_W = 3;

    // physical register tag
    localparam int PREG_W = 6;

    // recovery pc stored per branch entry
    localparam int PC_W = 16;

    // condition code and compare result, zero result means no branch this cycle
    localparam int COND_W = 2;

    // execution side ports
    localparam int NUM_DONE_PORTS = 4;
    localparam int NUM_ISSUE_PORTS = 4;

    // stop allocating once one more group would overflow
    localparam int FULL_LIMIT = ROB_DEPTH - GROUP_SIZE;

endpackage

`default_nettype wire

// ==== hw/rob_alloc_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module rob_alloc_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      alloc_vld,
    input  logic [rob_pkg::PTR_W-1:0] head_ptr,
    input  logic                      mis_pred,
    input  logic [rob_pkg::IDX_W-1:0] mis_pred_idx,
    output logic [rob_pkg::PTR_W-1:0] tail_ptr,
    output logic                      alloc_en,
    output logic                      rob_full,
    output logic                      rob_empty
);

    logic [rob_pkg::PTR_W-1:0] occupancy;
    logic [rob_pkg::IDX_W-1:0] brnc_dist;
    logic [rob_pkg::PTR_W-1:0] rollback_ptr;

    // wrap bit keeps occupancy 64 apart from 0
    assign occupancy = tail_ptr - head_ptr;
    assign rob_empty = (occupancy == '0);
    assign rob_full  = (occupancy > (rob_pkg::PTR_W)'(rob_pkg::FULL_LIMIT));

    // strobe is dropped while full or during a flush
    assign alloc_en = alloc_vld && !rob_full && !mis_pred;

    // distance from head to the branch, in entries
    assign brnc_dist = mis_pred_idx - head_ptr[rob_pkg::IDX_W-1:0];

    // tail lands one past the branch; the carry sets the right wrap bit
    assign rollback_ptr = head_ptr
                        + (rob_pkg::PTR_W)'(brnc_dist)
                        + (rob_pkg::PTR_W)'(1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tail_ptr <= '0;
        end else if (mis_pred) begin
            tail_ptr <= rollback_ptr;
        end else if (alloc_en) begin
            tail_ptr <= tail_ptr + (rob_pkg::PTR_W)'(rob_pkg::GROUP_SIZE);
        end
    end

endmodule

`default_nettype wire

// ==== hw/rob_entry_array.sv ====
`timescale 1ns/10ps
`default_nettype none

module rob_entry_array (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic                                                alloc_en,
    input  logic [rob_pkg::IDX_W-1:0]                           tail_idx,
    input  logic [rob_pkg::GROUP_SIZE-1:0]                      brnc_in,
    input  logic [rob_pkg::GROUP_SIZE-1:0]                      brnc_pred,
    input  logic [rob_pkg::GROUP_SIZE-1:0]                      reg_wrt_in,
    input  logic [rob_pkg::GROUP_SIZE*rob_pkg::COND_W-1:0]      brnc_cond,
    input  logic [rob_pkg::GROUP_SIZE*rob_pkg::PC_W-1:0]        rcvr_pc,
    input  logic [rob_pkg::NUM_ISSUE_PORTS-1:0]                 iss_vld,
    input  logic [rob_pkg::NUM_ISSUE_PORTS*rob_pkg::IDX_W-1:0]  iss_idx,
    input  logic [rob_pkg::NUM_ISSUE_PORTS*rob_pkg::PREG_W-1:0] iss_free_preg,
    input  logic [rob_pkg::NUM_DONE_PORTS-1:0]                  done_vld,
    input  logic [rob_pkg::NUM_DONE_PORTS*rob_pkg::IDX_W-1:0]   done_idx,
    input  logic [rob_pkg::IDX_W-1:0]                           brnc_idx,
    input  logic                                                brnc_ok,
    input  logic                                                mis_pred,
    input  logic [rob_pkg::IDX_W-1:0]                           head_idx,
    input  logic [rob_pkg::CNT_W-1:0]                           commit_cnt,
    output logic                                                br_vld,
    output logic                                                br_is_brnc,
    output logic                                                br_pred,
    output logic [rob_pkg::COND_W-1:0]                          br_cond,
    output logic [rob_pkg::PC_W-1:0]                            br_pc,
    output logic [rob_pkg::COMMIT_WIDTH-1:0]                    win_vld,
    output logic [rob_pkg::COMMIT_WIDTH-1:0]                    win_done,
    output logic [rob_pkg::COMMIT_WIDTH-1:0]                    win_reg_wrt,
    output logic [rob_pkg::COMMIT_WIDTH*rob_pkg::PREG_W-1:0]    win_free_preg
);

    // per-entry state
    logic [rob_pkg::ROB_DEPTH-1:0] ent_vld;
    logic [rob_pkg::ROB_DEPTH-1:0] ent_done;
    logic [rob_pkg::ROB_DEPTH-1:0] ent_brnc;
    logic [rob_pkg::ROB_DEPTH-1:0] ent_pred;
    logic [rob_pkg::ROB_DEPTH-1:0] ent_reg_wrt;
    logic [rob_pkg::COND_W-1:0]    ent_cond      [rob_pkg::ROB_DEPTH];
    logic [rob_pkg::PC_W-1:0]      ent_pc        [rob_pkg::ROB_DEPTH];
    logic [rob_pkg::PREG_W-1:0]    ent_free_preg [rob_pkg::ROB_DEPTH];

    // write decode
    logic [rob_pkg::ROB_DEPTH-1:0] alloc_hit;
    logic [rob_pkg::ROB_DEPTH-1:0] clr_hit;
    logic [rob_pkg::ROB_DEPTH-1:0] kill_hit;
    logic [rob_pkg::ROB_DEPTH-1:0] done_hit;
    logic [rob_pkg::IDX_W-1:0]     alloc_ofs [rob_pkg::ROB_DEPTH];
    logic [rob_pkg::IDX_W-1:0]     brnc_ofs;

    // branch age relative to head
    assign brnc_ofs = brnc_idx - head_idx;

    always_comb begin
        logic [rob_pkg::IDX_W-1:0] ent;
        logic [rob_pkg::IDX_W-1:0] head_ofs;
        logic                      fu_done;
        for (int i = 0; i < rob_pkg::ROB_DEPTH; i++) begin
            ent = (rob_pkg::IDX_W)'(i);
            alloc_ofs[i] = ent - tail_idx;
            head_ofs = ent - head_idx;
            alloc_hit[i] = alloc_en
                        && (alloc_ofs[i] < (rob_pkg::IDX_W)'(rob_pkg::GROUP_SIZE));
            clr_hit[i] = (head_ofs < (rob_pkg::IDX_W)'(commit_cnt));
            // everything younger than the branch is flushed
            kill_hit[i] = mis_pred && (head_ofs > brnc_ofs);
            fu_done = 1'b0;
            for (int p = 0; p < rob_pkg::NUM_DONE_PORTS; p++) begin
                if (done_vld[p] && (done_idx[p*rob_pkg::IDX_W +: rob_pkg::IDX_W] == ent)) begin
                    fu_done = 1'b1;
                end
            end
            if ((brnc_ok || mis_pred) && (brnc_idx == ent)) begin
                fu_done = 1'b1;
            end
            done_hit[i] = ent_vld[i] && fu_done;
        end
    end

    // allocate, then commit, then flush, then completion
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ent_vld  <= '0;
            ent_done <= '0;
        end else begin
            for (int i = 0; i < rob_pkg::ROB_DEPTH; i++) begin
                if (alloc_hit[i]) begin
                    ent_vld[i]  <= 1'b1;
                    ent_done[i] <= 1'b0;
                end else if (clr_hit[i]) begin
                    ent_vld[i]  <= 1'b0;
                    ent_done[i] <= 1'b0;
                end else if (kill_hit[i]) begin
                    ent_vld[i]  <= 1'b0;
                    ent_done[i] <= 1'b0;
                end else if (done_hit[i]) begin
                    ent_done[i] <= 1'b1;
                end
            end
        end
    end

    // payload fields written at allocation and issue
    always_ff @(posedge clk) begin
        for (int i = 0; i < rob_pkg::ROB_DEPTH; i++) begin
            if (alloc_hit[i]) begin
                ent_brnc[i]    <= brnc_in[int'(alloc_ofs[i])];
                ent_pred[i]    <= brnc_pred[int'(alloc_ofs[i])];
                ent_reg_wrt[i] <= reg_wrt_in[int'(alloc_ofs[i])];
                ent_cond[i]    <= brnc_cond[alloc_ofs[i]*rob_pkg::COND_W +: rob_pkg::COND_W];
                ent_pc[i]      <= rcvr_pc[alloc_ofs[i]*rob_pkg::PC_W +: rob_pkg::PC_W];
            end
            // issue records the register freed at commit
            for (int p = 0; p < rob_pkg::NUM_ISSUE_PORTS; p++) begin
                if (iss_vld[p]
                    && (iss_idx[p*rob_pkg::IDX_W +: rob_pkg::IDX_W] == (rob_pkg::IDX_W)'(i))) begin
                    ent_free_preg[i] <= iss_free_preg[p*rob_pkg::PREG_W +: rob_pkg::PREG_W];
                end
            end
        end
    end

    // branch lookup for the resolving entry
    assign br_vld     = ent_vld[brnc_idx];
    assign br_is_brnc = ent_brnc[brnc_idx];
    assign br_pred    = ent_pred[brnc_idx];
    assign br_cond    = ent_cond[brnc_idx];
    assign br_pc      = ent_pc[brnc_idx];

    // four oldest entries from the head
    always_comb begin
        logic [rob_pkg::IDX_W-1:0] w;
        for (int k = 0; k < rob_pkg::COMMIT_WIDTH; k++) begin
            w = head_idx + (rob_pkg::IDX_W)'(k);
            win_vld[k]     = ent_vld[w];
            win_done[k]    = ent_done[w];
            win_reg_wrt[k] = ent_reg_wrt[w];
            win_free_preg[k*rob_pkg::PREG_W +: rob_pkg::PREG_W] = ent_free_preg[w];
        end
    end

endmodule

`default_nettype wire

// ==== hw/rob_branch_check.sv ====
`timescale 1ns/10ps
`default_nettype none

module rob_branch_check (
    input  logic [rob_pkg::COND_W-1:0] brnc_cmp_rslt,
    input  logic                       br_vld,
    input  logic                       br_is_brnc,
    input  logic                       br_pred,
    input  logic [rob_pkg::COND_W-1:0] br_cond,
    input  logic [rob_pkg::PC_W-1:0]   br_pc,
    input  logic [rob_pkg::IDX_W-1:0]  brnc_idx,
    output logic                       mis_pred,
    output logic                       brnc_ok,
    output logic                       cmt_brnc,
    output logic [rob_pkg::IDX_W-1:0]  cmt_brnc_idx,
    output logic [rob_pkg::IDX_W-1:0]  mis_pred_brnc_idx,
    output logic [rob_pkg::PC_W-1:0]   rcvr_pc_out
);

    logic resolve;
    logic taken;

    // zero compare result means the register file has nothing this cycle
    assign resolve = (brnc_cmp_rslt != '0) && br_vld && br_is_brnc;

    // taken when the flags match the encoded condition
    assign taken = (brnc_cmp_rslt == br_cond);

    assign mis_pred = resolve && (br_pred != taken);
    assign brnc_ok  = resolve && (br_pred == taken);
    assign cmt_brnc = brnc_ok;

    assign cmt_brnc_idx      = brnc_idx;
    assign mis_pred_brnc_idx = brnc_idx;

    // fetch only sees a redirect target on a real flush
    assign rcvr_pc_out = mis_pred ? br_pc : '0;

endmodule

`default_nettype wire

// ==== hw/rob_commit_sel.sv ====
`timescale 1ns/10ps
`default_nettype none

module rob_commit_sel (
    input  logic                                             clk,
    input  logic                                             rst_n,
    input  logic [rob_pkg::COMMIT_WIDTH-1:0]                 win_vld,
    input  logic [rob_pkg::COMMIT_WIDTH-1:0]                 win_done,
    input  logic [rob_pkg::COMMIT_WIDTH-1:0]                 win_reg_wrt,
    input  logic [rob_pkg::COMMIT_WIDTH*rob_pkg::PREG_W-1:0] win_free_preg,
    output logic [rob_pkg::PTR_W-1:0]                        head_ptr,
    output logic [rob_pkg::CNT_W-1:0]                        commit_cnt,
    output logic [rob_pkg::CNT_W-1:0]                        free_preg_cnt,
    output logic [rob_pkg::COMMIT_WIDTH*rob_pkg::PREG_W-1:0] free_preg_num
);

    logic [rob_pkg::COMMIT_WIDTH-1:0] cmt_mask;

    // stop at the first entry that is not ready
    always_comb begin
        logic run;
        run = 1'b1;
        commit_cnt = '0;
        for (int k = 0; k < rob_pkg::COMMIT_WIDTH; k++) begin
            run = run && win_vld[k] && win_done[k];
            cmt_mask[k] = run;
            if (run) begin
                commit_cnt = (rob_pkg::CNT_W)'(k + 1);
            end
        end
    end

    // compact freed tags into the low slots, oldest first
    always_comb begin
        int slot;
        slot = 0;
        free_preg_num = '0;
        for (int k = 0; k < rob_pkg::COMMIT_WIDTH; k++) begin
            if (cmt_mask[k] && win_reg_wrt[k]) begin
                free_preg_num[slot*rob_pkg::PREG_W +: rob_pkg::PREG_W] =
                    win_free_preg[k*rob_pkg::PREG_W +: rob_pkg::PREG_W];
                slot = slot + 1;
            end
        end
        free_preg_cnt = (rob_pkg::CNT_W)'(slot);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_ptr <= '0;
        end else begin
            head_ptr <= head_ptr + (rob_pkg::PTR_W)'(commit_cnt);
        end
    end

endmodule

`default_nettype wire

// ==== hw/rob_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module rob_top (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic                                                alloc_vld,
    input  logic [rob_pkg::GROUP_SIZE-1:0]                      brnc_in,
    input  logic [rob_pkg::GROUP_SIZE-1:0]                      brnc_pred,
    input  logic [rob_pkg::GROUP_SIZE*rob_pkg::COND_W-1:0]      brnc_cond,
    input  logic [rob_pkg::GROUP_SIZE*rob_pkg::PC_W-1:0]        rcvr_pc,
    input  logic [rob_pkg::GROUP_SIZE-1:0]                      reg_wrt_in,
    input  logic [rob_pkg::NUM_ISSUE_PORTS-1:0]                 iss_vld,
    input  logic [rob_pkg::NUM_ISSUE_PORTS*rob_pkg::IDX_W-1:0]  iss_idx,
    input  logic [rob_pkg::NUM_ISSUE_PORTS*rob_pkg::PREG_W-1:0] iss_free_preg,
    input  logic [rob_pkg::NUM_DONE_PORTS-1:0]                  done_vld,
    input  logic [rob_pkg::NUM_DONE_PORTS*rob_pkg::IDX_W-1:0]   done_idx,
    input  logic [rob_pkg::IDX_W-1:0]                           brnc_idx,
    input  logic [rob_pkg::COND_W-1:0]                          brnc_cmp_rslt,
    output logic [rob_pkg::IDX_W-1:0]                           next_idx,
    output logic                                                mis_pred,
    output logic [rob_pkg::IDX_W-1:0]                           mis_pred_brnc_idx,
    output logic                                                cmt_brnc,
    output logic [rob_pkg::IDX_W-1:0]                           cmt_brnc_idx,
    output logic [rob_pkg::PC_W-1:0]                            rcvr_pc_out,
    output logic                                                rob_full,
    output logic                                                rob_empty,
    output logic [rob_pkg::CNT_W-1:0]                           commit_cnt,
    output logic [rob_pkg::CNT_W-1:0]                           free_preg_cnt,
    output logic [rob_pkg::COMMIT_WIDTH*rob_pkg::PREG_W-1:0]    free_preg_num
);

    logic [rob_pkg::PTR_W-1:0]                        tail_ptr;
    logic [rob_pkg::PTR_W-1:0]                        head_ptr;
    logic                                             alloc_en;
    logic                                             brnc_ok;
    logic                                             br_vld;
    logic                                             br_is_brnc;
    logic                                             br_pred;
    logic [rob_pkg::COND_W-1:0]                       br_cond;
    logic [rob_pkg::PC_W-1:0]                         br_pc;
    logic [rob_pkg::COMMIT_WIDTH-1:0]                 win_vld;
    logic [rob_pkg::COMMIT_WIDTH-1:0]                 win_done;
    logic [rob_pkg::COMMIT_WIDTH-1:0]                 win_reg_wrt;
    logic [rob_pkg::COMMIT_WIDTH*rob_pkg::PREG_W-1:0] win_free_preg;

    // allocation stage tags the next group from here
    assign next_idx = tail_ptr[rob_pkg::IDX_W-1:0];

    rob_alloc_ctrl u_alloc_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .alloc_vld    (alloc_vld),
        .head_ptr     (head_ptr),
        .mis_pred     (mis_pred),
        .mis_pred_idx (mis_pred_brnc_idx),
        .tail_ptr     (tail_ptr),
        .alloc_en     (alloc_en),
        .rob_full     (rob_full),
        .rob_empty    (rob_empty)
    );

    rob_entry_array u_entry_array (
        .clk           (clk),
        .rst_n         (rst_n),
        .alloc_en      (alloc_en),
        .tail_idx      (tail_ptr[rob_pkg::IDX_W-1:0]),
        .brnc_in       (brnc_in),
        .brnc_pred     (brnc_pred),
        .reg_wrt_in    (reg_wrt_in),
        .brnc_cond     (brnc_cond),
        .rcvr_pc       (rcvr_pc),
        .iss_vld       (iss_vld),
        .iss_idx       (iss_idx),
        .iss_free_preg (iss_free_preg),
        .done_vld      (done_vld),
        .done_idx      (done_idx),
        .brnc_idx      (brnc_idx),
        .brnc_ok       (brnc_ok),
        .mis_pred      (mis_pred),
        .head_idx      (head_ptr[rob_pkg::IDX_W-1:0]),
        .commit_cnt    (commit_cnt),
        .br_vld        (br_vld),
        .br_is_brnc    (br_is_brnc),
        .br_pred       (br_pred),
        .br_cond       (br_cond),
        .br_pc         (br_pc),
        .win_vld       (win_vld),
        .win_done      (win_done),
        .win_reg_wrt   (win_reg_wrt),
        .win_free_preg (win_free_preg)
    );

    rob_branch_check u_branch_check (
        .brnc_cmp_rslt     (brnc_cmp_rslt),
        .br_vld            (br_vld),
        .br_is_brnc        (br_is_brnc),
        .br_pred           (br_pred),
        .br_cond           (br_cond),
        .br_pc             (br_pc),
        .brnc_idx          (brnc_idx),
        .mis_pred          (mis_pred),
        .brnc_ok           (brnc_ok),
        .cmt_brnc          (cmt_brnc),
        .cmt_brnc_idx      (cmt_brnc_idx),
        .mis_pred_brnc_idx (mis_pred_brnc_idx),
        .rcvr_pc_out       (rcvr_pc_out)
    );

    rob_commit_sel u_commit_sel (
        .clk           (clk),
        .rst_n         (rst_n),
        .win_vld       (win_vld),
        .win_done      (win_done),
        .win_reg_wrt   (win_reg_wrt),
        .win_free_preg (win_free_preg),
        .head_ptr      (head_ptr),
        .commit_cnt    (commit_cnt),
        .free_preg_cnt (free_preg_cnt),
        .free_preg_num (free_preg_num)
    );

endmodule

`default_nettype wire

// ==== sim/rob_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module rob_tb;

    // reset 16, then roughly 1 + 16 + 16 + 70 + 11 + 67 cycles of tests
    localparam int TEST_CYCLES = 200;
    localparam int MAX_CYCLES = 2 * TEST_CYCLES;

    logic                                             clk;
    logic                                             rst_n;
    logic                                             alloc_vld;
    logic [rob_pkg::GROUP_SIZE-1:0]                   brnc_in;
    logic [rob_pkg::GROUP_SIZE-1:0]                   brnc_pred;
    logic [rob_pkg::GROUP_SIZE*rob_pkg::COND_W-1:0]   brnc_cond;
    logic [rob_pkg::GROUP_SIZE*rob_pkg::PC_W-1:0]     rcvr_pc;
    logic [rob_pkg::GROUP_SIZE-1:0]                   reg_wrt_in;
    logic [rob_pkg::NUM_ISSUE_PORTS-1:0]              iss_vld;
    logic [rob_pkg::NUM_ISSUE_PORTS*rob_pkg::IDX_W-1:0]  iss_idx;
    logic [rob_pkg::NUM_ISSUE_PORTS*rob_pkg::PREG_W-1:0] iss_free_preg;
    logic [rob_pkg::NUM_DONE_PORTS-1:0]               done_vld;
    logic [rob_pkg::NUM_DONE_PORTS*rob_pkg::IDX_W-1:0]   done_idx;
    logic [rob_pkg::IDX_W-1:0]                        brnc_idx;
    logic [rob_pkg::COND_W-1:0]                       brnc_cmp_rslt;
    logic [rob_pkg::IDX_W-1:0]                        next_idx;
    logic                                             mis_pred;
    logic [rob_pkg::IDX_W-1:0]                        mis_pred_brnc_idx;
    logic                                             cmt_brnc;
    logic [rob_pkg::IDX_W-1:0]                        cmt_brnc_idx;
    logic [rob_pkg::PC_W-1:0]                         rcvr_pc_out;
    logic                                             rob_full;
    logic                                             rob_empty;
    logic [rob_pkg::CNT_W-1:0]                        commit_cnt;
    logic [rob_pkg::CNT_W-1:0]                        free_preg_cnt;
    logic [rob_pkg::COMMIT_WIDTH*rob_pkg::PREG_W-1:0] free_preg_num;

    int          checks = 0;
    int          errors = 0;
    int          width_errors = 0;
    int          cycle_cnt = 0;
    int          cmt_total = 0;
    logic [31:0] lcg_state = 32'd93;
    logic [rob_pkg::PREG_W-1:0] freed_q [$];

    // branch outputs sampled in the result cycle
    logic                      got_mis;
    logic                      got_cmt;
    logic [rob_pkg::IDX_W-1:0] got_cmt_idx;
    logic [rob_pkg::IDX_W-1:0] got_mis_idx;
    logic [rob_pkg::PC_W-1:0]  got_pc;

    rob_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > MAX_CYCLES) begin
            $display("timeout after %0d cycles, the tests did not finish", MAX_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // every retirement, with freed tags kept in program order
    always @(negedge clk) begin
        if (rst_n) begin
            if (commit_cnt > 3'(rob_pkg::COMMIT_WIDTH)) begin
                width_errors++;
                $display("more than four entries committed in one cycle (%0d)", commit_cnt);
            end
            cmt_total += int'(commit_cnt);
            for (int k = 0; k < rob_pkg::COMMIT_WIDTH; k++) begin
                if (k < int'(free_preg_cnt)) begin
                    freed_q.push_back(free_preg_num[k*rob_pkg::PREG_W +: rob_pkg::PREG_W]);
                end
            end
        end
    end

    task automatic compare(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // four random tags, slot 0 in the low bits
    function automatic logic [23:0] rand_pregs();
        logic [31:0] r;
        logic [23:0] v;
        for (int k = 0; k < 4; k++) begin
            r = lcg_next();
            v[k*6 +: 6] = r[21:16];
        end
        return v;
    endfunction

    function automatic logic [23:0] quad(input logic [5:0] base);
        return {base + 6'd3, base + 6'd2, base + 6'd1, base};
    endfunction

    task automatic alloc_group(input logic [3:0] brnc, input logic [3:0] pred,
                               input logic [3:0] wrt, input logic [7:0] cond,
                               input logic [63:0] pc);
        @(posedge clk);
        alloc_vld  <= 1'b1;
        brnc_in    <= brnc;
        brnc_pred  <= pred;
        reg_wrt_in <= wrt;
        brnc_cond  <= cond;
        rcvr_pc    <= pc;
        @(posedge clk);
        alloc_vld <= 1'b0;
    endtask

    task automatic issue_group(input logic [5:0] base, input logic [3:0] wrt,
                               input logic [23:0] pregs);
        @(posedge clk);
        iss_vld       <= wrt;
        iss_idx       <= quad(base);
        iss_free_preg <= pregs;
        @(posedge clk);
        iss_vld <= '0;
    endtask

    task automatic complete_set(input logic [3:0] vld, input logic [23:0] idxs);
        @(posedge clk);
        done_vld <= vld;
        done_idx <= idxs;
        @(posedge clk);
        done_vld <= '0;
    endtask

    task automatic resolve_branch(input logic [5:0] idx, input logic [1:0] rslt);
        @(posedge clk);
        brnc_idx      <= idx;
        brnc_cmp_rslt <= rslt;
        @(negedge clk);
        got_mis     = mis_pred;
        got_cmt     = cmt_brnc;
        got_cmt_idx = cmt_brnc_idx;
        got_mis_idx = mis_pred_brnc_idx;
        got_pc      = rcvr_pc_out;
        @(posedge clk);
        brnc_cmp_rslt <= '0;
    endtask

    task automatic wait_empty(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (!rob_empty && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!rob_empty) begin
            errors++;
            $display("buffer still not empty after %0d cycles", limit);
        end
        // monitor has counted the last commit by now
        @(posedge clk);
    endtask

    task automatic reset_state();
        @(negedge clk);
        compare("rob_empty", 32'(rob_empty), 1);
        compare("rob_full", 32'(rob_full), 0);
        compare("next_idx", 32'(next_idx), 0);
        compare("free_preg_cnt", 32'(free_preg_cnt), 0);
        compare("mis_pred", 32'(mis_pred), 0);
        compare("cmt_brnc", 32'(cmt_brnc), 0);
    endtask

    task automatic in_order_commit();
        logic [23:0] pregs;
        logic [23:0] exp_num;
        pregs = rand_pregs();
        // slots 0, 1 and 3 write a register
        alloc_group(4'h0, 4'h0, 4'b1011, 8'h0, 64'h0);
        @(negedge clk);
        compare("next_idx", 32'(next_idx), 4);
        issue_group(6'd0, 4'b1011, pregs);
        for (int i = 3; i >= 1; i--) begin
            complete_set(4'b0001, {18'd0, 6'(i)});
            @(negedge clk);
            compare("commit_cnt", 32'(commit_cnt), 0);
        end
        complete_set(4'b0001, 24'd0);
        @(negedge clk);
        exp_num = {6'd0, pregs[23:18], pregs[11:6], pregs[5:0]};
        compare("commit_cnt", 32'(commit_cnt), 4);
        compare("free_preg_cnt", 32'(free_preg_cnt), 3);
        compare("free_preg_num", 32'(free_preg_num), 32'(exp_num));
        wait_empty(8);
    endtask

    task automatic commit_width();
        logic [47:0] all_pregs;
        int          start;
        int          qbase;
        all_pregs = {rand_pregs(), rand_pregs()};
        start = cmt_total;
        qbase = freed_q.size();
        alloc_group(4'h0, 4'h0, 4'hf, 8'h0, 64'h0);
        alloc_group(4'h0, 4'h0, 4'hf, 8'h0, 64'h0);
        issue_group(6'd4, 4'hf, all_pregs[23:0]);
        issue_group(6'd8, 4'hf, all_pregs[47:24]);
        // oldest entry finishes last, so all eight are ready at once
        complete_set(4'hf, {6'd8, 6'd7, 6'd6, 6'd5});
        complete_set(4'hf, {6'd4, 6'd11, 6'd10, 6'd9});
        @(negedge clk);
        compare("commit_cnt", 32'(commit_cnt), 4);
        wait_empty(8);
        compare("committed", cmt_total - start, 8);
        compare("freed count", freed_q.size() - qbase, 8);
        for (int k = 0; k < 8; k++) begin
            compare("freed tag", 32'(freed_q[qbase + k]), 32'(all_pregs[k*6 +: 6]));
        end
    endtask

    task automatic full_flag();
        logic [5:0] exp_next;
        logic [5:0] base;
        int         start;
        start = cmt_total;
        // three groups went in before this test
        exp_next = 6'd12;
        for (int n = 1; n <= 16; n++) begin
            alloc_group(4'h0, 4'h0, 4'h0, 8'h0, 64'h0);
            exp_next = exp_next + 6'd4;
            @(negedge clk);
            compare("next_idx", 32'(next_idx), 32'(exp_next));
            compare("rob_full", 32'(rob_full), (n * 4 > rob_pkg::FULL_LIMIT) ? 1 : 0);
        end
        alloc_group(4'h0, 4'h0, 4'h0, 8'h0, 64'h0);
        @(negedge clk);
        compare("next_idx", 32'(next_idx), 32'(exp_next));
        compare("rob_full", 32'(rob_full), 1);
        for (int g = 0; g < 16; g++) begin
            base = 6'd12 + 6'(4 * g);
            complete_set(4'hf, quad(base));
        end
        wait_empty(8);
        compare("committed", cmt_total - start, 64);
    endtask

    task automatic correct_branch();
        int start;
        start = cmt_total;
        // slot 0 predicted taken, taken on condition 01
        alloc_group(4'b0001, 4'b0001, 4'h0, 8'h01, 64'h1234);
        resolve_branch(6'd12, 2'b01);
        compare("mis_pred", 32'(got_mis), 0);
        compare("cmt_brnc", 32'(got_cmt), 1);
        compare("cmt_brnc_idx", 32'(got_cmt_idx), 12);
        complete_set(4'b1110, quad(6'd12));
        wait_empty(8);
        compare("committed", cmt_total - start, 4);
        @(negedge clk);
        compare("next_idx", 32'(next_idx), 16);
    endtask

    task automatic mispredict_wrap();
        logic [5:0] base;
        int         start;
        // walk the tail round to 60
        for (int g = 0; g < 11; g++) begin
            base = 6'd16 + 6'(4 * g);
            alloc_group(4'h0, 4'h0, 4'h0, 8'h0, 64'h0);
            complete_set(4'hf, quad(base));
        end
        wait_empty(8);
        start = cmt_total;
        @(negedge clk);
        compare("next_idx", 32'(next_idx), 60);
        // slot 1 predicted not taken on condition 10
        alloc_group(4'b0010, 4'h0, 4'h0, 8'b0000_1000, {32'h0, 16'hbeef, 16'h0});
        alloc_group(4'h0, 4'h0, 4'h0, 8'h0, 64'h0);
        @(negedge clk);
        compare("next_idx", 32'(next_idx), 4);
        resolve_branch(6'd61, 2'b10);
        compare("mis_pred", 32'(got_mis), 1);
        compare("mis_pred_brnc_idx", 32'(got_mis_idx), 61);
        compare("rcvr_pc_out", 32'(got_pc), 32'hbeef);
        compare("cmt_brnc", 32'(got_cmt), 0);
        @(negedge clk);
        // one past the branch
        compare("next_idx", 32'(next_idx), 62);
        complete_set(4'hf, {6'd0, 6'd63, 6'd62, 6'd60});
        complete_set(4'b0111, {6'd0, 6'd3, 6'd2, 6'd1});
        wait_empty(8);
        repeat (4) @(posedge clk);
        compare("committed", cmt_total - start, 2);
        @(negedge clk);
        compare("next_idx", 32'(next_idx), 62);
        compare("rob_empty", 32'(rob_empty), 1);
    endtask

    initial begin
        rst_n         <= 1'b0;
        alloc_vld     <= 1'b0;
        brnc_in       <= '0;
        brnc_pred     <= '0;
        brnc_cond     <= '0;
        rcvr_pc       <= '0;
        reg_wrt_in    <= '0;
        iss_vld       <= '0;
        iss_idx       <= '0;
        iss_free_preg <= '0;
        done_vld      <= '0;
        done_idx      <= '0;
        brnc_idx      <= '0;
        brnc_cmp_rslt <= '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        reset_state();
        in_order_commit();
        commit_width();
        full_flag();
        correct_branch();
        mispredict_wrap();
        $display("checks %0d, errors %0d, commit width errors %0d",
                 checks, errors, width_errors);
        if (errors == 0 && width_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rob_top.f ====
hw/rob_pkg.sv
hw/rob_alloc_ctrl.sv
hw/rob_entry_array.sv
hw/rob_branch_check.sv
hw/rob_commit_sel.sv
hw/rob_top.sv
sim/rob_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the reorder buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module rob_tb -f rob_top.f -o rob_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/rob_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "^PASS: all tests$"; then
    exit 0
fi
echo "pass message not found"
exit 1
